//--- flist.f
+incdir+hw
hw/x86_mem_pkg.sv
hw/seg_reg_file.sv
hw/mem_cmd_decode.sv
hw/load_store_unit.sv
hw/load_writeback.sv
hw/mem_subsystem_top.sv
tests/bus_memory_model.sv
tests/tb_mem_subsystem.sv

//--- hw/load_store_unit.sv
// One access at a time, unaligned words split into two byte cycles, byte loads are zero-extended
`timescale 1ns/10ps
`include "x86_mem_defs.svh"

module load_store_unit (
  input  logic                      clk,
  input  logic                      reset,
  // Memory address register
  input  logic                      write_addr,
  input  logic [`X86_OFFSET_W-1:0]  addr_in,
  // Memory data register
  input  logic                      write_data,
  input  logic [`X86_OFFSET_W-1:0]  data_in,
  // Orders
  input  logic                      mem_read,
  input  logic                      mem_write,
  input  logic                      io,
  input  logic                      is_8bit,
  input  logic [`X86_OFFSET_W-1:0]  segment,
  // Memory bus
  output x86_mem_pkg::bus_req_t     bus,
  input  logic [`X86_OFFSET_W-1:0]  bus_rdata,
  input  logic                      bus_ack,
  // Result
  output logic [`X86_OFFSET_W-1:0]  data_out,
  output logic                      done
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_FIRST,   // High byte of a split word at the lower address
    SECOND,       // Raise the second byte cycle
    WAIT_LAST,
    FINISH
  } lsu_state_e;

  lsu_state_e state;

  logic [`X86_OFFSET_W-1:0] mar;
  logic [`X86_OFFSET_W-1:0] mdr;

  logic                     unaligned;
  logic                     split;
  logic                     high_lane;
  logic [`X86_PADDR_W-1:1]  mem_word_addr;
  logic [`X86_PADDR_W-1:1]  io_word_addr;
  logic [1:0]               first_sel;
  logic [`X86_OFFSET_W-1:0] first_wdata;

  // ========================================
  // Address and lane decisions
  // ========================================

  assign unaligned = mar[0] & ~io;        // I/O ports are never split
  assign split     = unaligned & ~is_8bit;
  assign high_lane = unaligned & is_8bit;

  // Segment times 16 plus offset, shifted down to a word address
  assign mem_word_addr = {segment, 3'b000} + {4'b0000, mar[`X86_OFFSET_W-1:1]};
  assign io_word_addr  = {3'b000, mar};   // Port number as is

  always_comb begin
    if (unaligned) begin
      first_sel   = 2'b10;
      first_wdata = {mdr[7:0], 8'h00};
    end else if (is_8bit) begin
      first_sel   = 2'b01;
      first_wdata = {8'h00, mdr[7:0]};
    end else begin
      first_sel   = 2'b11;
      first_wdata = mdr;
    end
  end

  // ========================================
  // Bus state machine
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
      bus   <= '0;
      done  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Wait out the register load cycle before using mar
          if ((mem_read | mem_write) && !write_addr) begin
            bus.addr    <= io ? io_word_addr : mem_word_addr;
            bus.io      <= io;
            bus.wr_en   <= mem_write;
            bus.bytesel <= first_sel;
            bus.wdata   <= mem_write ? first_wdata : '0;
            bus.access  <= 1'b1;
            state       <= split ? WAIT_FIRST : WAIT_LAST;
          end
        end

        WAIT_FIRST: begin
          if (bus_ack) begin
            bus.access  <= 1'b0;
            bus.wr_en   <= 1'b0;
            bus.bytesel <= 2'b00;
            bus.wdata   <= '0;
            bus.addr    <= bus.addr + 1'b1;  // Next word holds the upper byte
            state       <= SECOND;
          end
        end

        SECOND: begin
          bus.access  <= 1'b1;
          bus.wr_en   <= mem_write;
          bus.bytesel <= 2'b01;
          bus.wdata   <= mem_write ? {8'h00, mdr[15:8]} : '0;
          state       <= WAIT_LAST;
        end

        WAIT_LAST: begin
          if (bus_ack) begin
            bus   <= '0;     // Quiet bus between accesses
            done  <= 1'b1;
            state <= FINISH;
          end
        end

        FINISH: begin
          done  <= 1'b0;
          state <= IDLE;     // Orders are already low here
        end

        default: begin
          bus   <= '0;
          done  <= 1'b0;
          state <= IDLE;
        end
      endcase
    end
  end

  // ========================================
  // Address and data registers
  // ========================================

  always_ff @(posedge clk) begin
    if (write_addr) begin
      mar <= addr_in;
    end
  end

  // Load data lands here and is packed lane by lane
  always_ff @(posedge clk) begin
    if (write_data) begin
      mdr <= data_in;
    end else if (bus_ack && mem_read) begin
      if (state == WAIT_FIRST) begin
        mdr[7:0] <= bus_rdata[15:8];
      end else if (state == WAIT_LAST) begin
        if (split) begin
          mdr[15:8] <= bus_rdata[7:0];
        end else if (high_lane) begin
          mdr <= {8'h00, bus_rdata[15:8]};
        end else if (is_8bit) begin
          mdr <= {8'h00, bus_rdata[7:0]};
        end else begin
          mdr <= bus_rdata;
        end
      end
    end
  end

  assign data_out = mdr;

endmodule

//--- hw/load_writeback.sv
// Completion becomes a one-cycle write-back for loads or a store-done pulse for stores
`timescale 1ns/10ps
`include "x86_mem_defs.svh"

module load_writeback (
  input  logic                      clk,
  input  logic                      reset,
  // From the load/store unit and decode
  input  logic                      done,
  input  logic                      is_read,
  input  logic [`X86_REG_TAG_W-1:0] dest_tag,
  input  logic [`X86_OFFSET_W-1:0]  data_out,
  // Register file side
  output logic                      wb_valid,
  output x86_mem_pkg::wb_t          wb,
  output logic                      store_done
);

  // ========================================
  // Result pulses
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_valid   <= 1'b0;
      store_done <= 1'b0;
    end else begin
      wb_valid   <= done & is_read;
      store_done <= done & ~is_read;   // Covers I/O writes too
    end
  end

  // Tag and data captured with the pulse
  always_ff @(posedge clk) begin
    if (done && is_read) begin
      wb.tag  <= dest_tag;
      wb.data <= data_out;
    end
  end

endmodule

//--- hw/mem_cmd_decode.sv
// Accepts one command at a time, a strobe while busy is dropped, orders stay up until done
`timescale 1ns/10ps
`include "x86_mem_defs.svh"

module mem_cmd_decode (
  input  logic                      clk,
  input  logic                      reset,
  // Command port
  input  logic                      cmd_valid,
  input  x86_mem_pkg::mem_cmd_t     cmd,
  output logic                      busy,
  // Completion from the load/store unit
  input  logic                      done,
  // Address and data register loads
  output logic                      write_addr,
  output logic [`X86_OFFSET_W-1:0]  addr_in,
  output logic                      write_data,
  output logic [`X86_OFFSET_W-1:0]  data_in,
  // Orders and access attributes
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      io,
  output logic                      is_8bit,
  output logic [`X86_SEG_IDX_W-1:0] seg_sel,
  // Held for the write-back stage
  output logic                      is_read,
  output logic [`X86_REG_TAG_W-1:0] dest_tag
);

  logic accept;

  assign accept = cmd_valid & ~busy;

  // ========================================
  // Control levels
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy       <= 1'b0;
      write_addr <= 1'b0;
      write_data <= 1'b0;
      mem_read   <= 1'b0;
      mem_write  <= 1'b0;
      io         <= 1'b0;
    end else begin
      write_addr <= accept; // One-cycle register loads
      write_data <= accept;
      if (accept) begin
        busy <= 1'b1;
        case (cmd.op)
          x86_mem_pkg::mem_read: begin
            mem_read  <= 1'b1;
            mem_write <= 1'b0;
            io        <= 1'b0;
          end
          x86_mem_pkg::mem_write: begin
            mem_read  <= 1'b0;
            mem_write <= 1'b1;
            io        <= 1'b0;
          end
          x86_mem_pkg::io_read: begin
            mem_read  <= 1'b1;
            mem_write <= 1'b0;
            io        <= 1'b1;
          end
          default: begin
            mem_read  <= 1'b0;
            mem_write <= 1'b1;
            io        <= 1'b1;
          end
        endcase
      end else if (done) begin
        busy      <= 1'b0;
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        io        <= 1'b0;
      end
    end
  end

  // Command payload, held for the whole access
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_in  <= cmd.offset;
      data_in  <= cmd.wdata;
      is_8bit  <= cmd.is_8bit;
      seg_sel  <= cmd.seg_sel;
      dest_tag <= cmd.dest_tag;
      is_read  <= (cmd.op == x86_mem_pkg::mem_read) | (cmd.op == x86_mem_pkg::io_read);
    end
  end

endmodule

//--- hw/mem_subsystem_top.sv
// Single outstanding access, commands strobed while busy is high are ignored
`timescale 1ns/10ps
`include "x86_mem_defs.svh"

module mem_subsystem_top (
  input  logic                      clk,
  input  logic                      reset,
  // Command port
  input  logic                      cmd_valid,
  input  x86_mem_pkg::mem_cmd_t     cmd,
  output logic                      busy,
  // Segment register writes
  input  logic                      seg_wr,
  input  logic [`X86_SEG_IDX_W-1:0] seg_wr_idx,
  input  logic [`X86_OFFSET_W-1:0]  seg_wr_data,
  // Memory bus
  output x86_mem_pkg::bus_req_t     bus,
  input  logic [`X86_OFFSET_W-1:0]  bus_rdata,
  input  logic                      bus_ack,
  // Results
  output logic                      wb_valid,
  output x86_mem_pkg::wb_t          wb,
  output logic                      store_done
);

  logic                      write_addr;
  logic [`X86_OFFSET_W-1:0]  addr_in;
  logic                      write_data;
  logic [`X86_OFFSET_W-1:0]  data_in;
  logic                      mem_read;
  logic                      mem_write;
  logic                      io;
  logic                      is_8bit;
  logic [`X86_SEG_IDX_W-1:0] seg_sel;
  logic [`X86_OFFSET_W-1:0]  segment;
  logic                      is_read;
  logic [`X86_REG_TAG_W-1:0] dest_tag;
  logic [`X86_OFFSET_W-1:0]  data_out;
  logic                      done;

  // ========================================
  // Decode, segments, execute, result
  // ========================================

  mem_cmd_decode mem_cmd_decode_inst (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .done       (done),
    .write_addr (write_addr),
    .addr_in    (addr_in),
    .write_data (write_data),
    .data_in    (data_in),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .io         (io),
    .is_8bit    (is_8bit),
    .seg_sel    (seg_sel),
    .is_read    (is_read),
    .dest_tag   (dest_tag)
  );

  seg_reg_file seg_reg_file_inst (
    .clk         (clk),
    .reset       (reset),
    .seg_wr      (seg_wr),
    .seg_wr_idx  (seg_wr_idx),
    .seg_wr_data (seg_wr_data),
    .seg_sel     (seg_sel),
    .segment     (segment)
  );

  load_store_unit load_store_unit_inst (
    .clk        (clk),
    .reset      (reset),
    .write_addr (write_addr),
    .addr_in    (addr_in),
    .write_data (write_data),
    .data_in    (data_in),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .io         (io),
    .is_8bit    (is_8bit),
    .segment    (segment),
    .bus        (bus),
    .bus_rdata  (bus_rdata),
    .bus_ack    (bus_ack),
    .data_out   (data_out),
    .done       (done)
  );

  load_writeback load_writeback_inst (
    .clk        (clk),
    .reset      (reset),
    .done       (done),
    .is_read    (is_read),
    .dest_tag   (dest_tag),
    .data_out   (data_out),
    .wb_valid   (wb_valid),
    .wb         (wb),
    .store_done (store_done)
  );

endmodule

//--- hw/seg_reg_file.sv
// Four segment registers cleared by reset, a write in the same cycle as a read returns the old value
`timescale 1ns/10ps
`include "x86_mem_defs.svh"

module seg_reg_file (
  input  logic                      clk,
  input  logic                      reset,
  // Write port
  input  logic                      seg_wr,
  input  logic [`X86_SEG_IDX_W-1:0] seg_wr_idx,
  input  logic [`X86_OFFSET_W-1:0]  seg_wr_data,
  // Read port
  input  logic [`X86_SEG_IDX_W-1:0] seg_sel,
  output logic [`X86_OFFSET_W-1:0]  segment
);

  logic [`X86_OFFSET_W-1:0] seg_q [`X86_NUM_SEG];

  // ========================================
  // Register array
  // ========================================

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `X86_NUM_SEG; i++) begin
        seg_q[i] <= '0;
      end
    end else if (seg_wr) begin
      seg_q[seg_wr_idx] <= seg_wr_data;
    end
  end

  // Combinational read for the address adder
  assign segment = seg_q[seg_sel];

endmodule

//--- hw/x86_mem_defs.svh
// Widths assume a 16-bit word bus with two byte lanes and a 20-bit physical space, no wrap rules
`ifndef X86_MEM_DEFS_SVH
`define X86_MEM_DEFS_SVH

// ========================================
// Data and address widths
// ========================================

// Offsets, segment values and data words share one width
`define X86_OFFSET_W 16

// Physical byte address, the bus carries bits 19 down to 1
`define X86_PADDR_W 20

// ========================================
// Register file sizes
// ========================================

`define X86_NUM_SEG   4   // ES, CS, SS, DS style set
`define X86_SEG_IDX_W 2   // Index into the segment set

`define X86_REG_TAG_W 3   // Destination register index

`endif

//--- hw/x86_mem_pkg.sv
// Shared command, bus and write-back types, field widths come from x86_mem_defs.svh
`include "x86_mem_defs.svh"

package x86_mem_pkg;

  // ========================================
  // Operations
  // ========================================

  typedef enum logic [1:0] {
    mem_read  = 2'd0,
    mem_write = 2'd1,
    io_read   = 2'd2,
    io_write  = 2'd3
  } mem_op_e;

  // ========================================
  // Command port payload
  // ========================================

  typedef struct packed {
    mem_op_e                     op;
    logic                        is_8bit;   // Byte access, else word
    logic [`X86_SEG_IDX_W-1:0]   seg_sel;   // Ignored for I/O
    logic [`X86_REG_TAG_W-1:0]   dest_tag;
    logic [`X86_OFFSET_W-1:0]    offset;    // Port number for I/O
    logic [`X86_OFFSET_W-1:0]    wdata;
  } mem_cmd_t;

  // Memory bus outputs
  typedef struct packed {
    logic [`X86_PADDR_W-1:1]     addr;      // Word address, or port number for I/O
    logic [`X86_OFFSET_W-1:0]    wdata;
    logic [1:0]                  bytesel;   // Bit 1 is the high byte lane
    logic                        wr_en;
    logic                        io;
    logic                        access;
  } bus_req_t;

  // Register write-back
  typedef struct packed {
    logic [`X86_REG_TAG_W-1:0]   tag;
    logic [`X86_OFFSET_W-1:0]    data;
  } wb_t;

endpackage

//--- tests/bus_memory_model.sv
// Sparse byte memory plus a separate I/O space, ack comes 1 to 4 cycles after a request is seen
`timescale 1ns/10ps
`include "x86_mem_defs.svh"

module bus_memory_model (
  input  logic                     clk,
  input  logic                     reset,
  input  x86_mem_pkg::bus_req_t    bus,
  output logic [`X86_OFFSET_W-1:0] bus_rdata,
  output logic                     bus_ack
);

  logic [7:0]               mem [int];
  logic [7:0]               io_mem [int];
  logic                     ack_q = 1'b0;
  logic [`X86_OFFSET_W-1:0] rdata_q = '0;
  logic [2:0]               wait_cnt = 3'd0;   // Cycles left until ack
  logic [31:0]              rnd;
  integer                   seed = 32'h0b1e27c5;

  assign bus_ack   = ack_q;
  assign bus_rdata = rdata_q;

  // Unwritten bytes read back a pattern built from every address bit
  function automatic logic [7:0] read_byte(input logic is_io,
                                           input logic [`X86_PADDR_W-1:0] a);
    logic [7:0] fill;
    fill = a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]} ^ (is_io ? 8'hc3 : 8'h5a);
    if (is_io) begin
      return io_mem.exists(int'(a)) ? io_mem[int'(a)] : fill;
    end
    return mem.exists(int'(a)) ? mem[int'(a)] : fill;
  endfunction

  task automatic write_byte(input logic is_io, input logic [`X86_PADDR_W-1:0] a,
                            input logic [7:0] d);
    if (is_io) begin
      io_mem[int'(a)] = d;
    end else begin
      mem[int'(a)] = d;
    end
  endtask

  // ========================================
  // Request handling
  // ========================================

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ack_q    <= 1'b0;
      rdata_q  <= '0;
      wait_cnt <= 3'd0;
    end else if (ack_q) begin
      ack_q    <= 1'b0;   // Request drops on this edge
      wait_cnt <= 3'd0;
    end else if (bus.access) begin
      if (wait_cnt == 3'd0) begin
        rnd = $random(seed);
        wait_cnt <= {1'b0, rnd[1:0]} + 3'd1;
      end else if (wait_cnt == 3'd1) begin
        if (bus.wr_en) begin
          if (bus.bytesel[0]) begin
            write_byte(bus.io, {bus.addr, 1'b0}, bus.wdata[7:0]);
          end
          if (bus.bytesel[1]) begin
            write_byte(bus.io, {bus.addr, 1'b1}, bus.wdata[15:8]);
          end
        end else begin
          // Both lanes always returned, the unit picks what it needs
          rdata_q <= {read_byte(bus.io, {bus.addr, 1'b1}), read_byte(bus.io, {bus.addr, 1'b0})};
        end
        ack_q    <= 1'b1;
        wait_cnt <= 3'd0;
      end else begin
        wait_cnt <= wait_cnt - 3'd1;
      end
    end
  end

endmodule

//--- tests/tb_mem_subsystem.sv
// One command at a time through the port with expected data from a byte map kept by the testbench
`timescale 1ns/10ps
`include "x86_mem_defs.svh"

module tb_mem_subsystem;

  localparam int NUM_ACCESSES   = 33;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = 40 * NUM_ACCESSES + RESET_CYCLES;

  logic                      clk = 1'b0;
  logic                      reset = 1'b1;
  logic                      cmd_valid;
  x86_mem_pkg::mem_cmd_t     cmd;
  logic                      busy;
  logic                      seg_wr;
  logic [`X86_SEG_IDX_W-1:0] seg_wr_idx;
  logic [`X86_OFFSET_W-1:0]  seg_wr_data;
  x86_mem_pkg::bus_req_t     bus;
  logic [`X86_OFFSET_W-1:0]  bus_rdata;
  logic                      bus_ack;
  logic                      wb_valid;
  x86_mem_pkg::wb_t          wb;
  logic                      store_done;

  logic [7:0]                ref_mem [int];   // Keyed by physical byte address
  logic [7:0]                ref_io [int];    // Keyed by port number and lane
  logic [`X86_OFFSET_W-1:0]  seg_vals [`X86_NUM_SEG];
  x86_mem_pkg::wb_t          exp_wb;
  x86_mem_pkg::bus_req_t     bus_log [$];     // One entry per bus cycle
  logic                      access_q;
  integer                    seed = 32'h0b1e27c5;
  string                     test_name = "none";
  int                        errors = 0;
  int                        errors_at_start = 0;
  int                        tests_run = 0;
  int                        tests_failed = 0;
  int                        cycles = 0;

  mem_subsystem_top mem_subsystem_top_inst (
    .clk         (clk),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .seg_wr      (seg_wr),
    .seg_wr_idx  (seg_wr_idx),
    .seg_wr_data (seg_wr_data),
    .busy        (busy),
    .bus         (bus),
    .bus_rdata   (bus_rdata),
    .bus_ack     (bus_ack),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .store_done  (store_done)
  );

  bus_memory_model bus_memory_model_inst (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: no completion within %0d cycles, run stopped", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Log every rising access so the address and lanes can be checked per command
  always @(posedge clk) begin
    if (reset) begin
      access_q <= 1'b0;
    end else begin
      if (bus.access && !access_q) begin
        bus_log.push_back(bus);
      end
      access_q <= bus.access;
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
  endtask

  task automatic note_problem(input string msg);
    errors++;
    $display("ERROR in %s: %s", test_name, msg);
  endtask

  // ========================================
  // Bus and write-back assertions
  // ========================================

  access_until_ack: assert property (@(posedge clk) disable iff (reset)
      bus.access && !bus_ack |=> bus.access)
    else note_problem("bus access dropped before the memory acknowledged");

  access_after_ack: assert property (@(posedge clk) disable iff (reset)
      bus_ack |=> !bus.access)
    else note_problem("bus access still high after the acknowledge");

  wb_matches_ref: assert property (@(posedge clk) disable iff (reset)
      wb_valid |-> wb == exp_wb)
    else report_mismatch("write-back", 32'(exp_wb), 32'(wb));

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
    end
    $display("%-14s %s", test_name, (errors == errors_at_start) ? "ok" : "FAILED");
  endtask

  function automatic logic [7:0] reference_byte(input logic is_io, input logic [19:0] a);
    if (is_io) begin
      return ref_io.exists(int'(a)) ? ref_io[int'(a)] : 8'hxx;
    end
    return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : 8'hxx;
  endfunction

  task automatic store_reference(input logic is_io, input logic [19:0] a, input logic [7:0] d);
    if (is_io) begin
      ref_io[int'(a)] = d;
    end else begin
      ref_mem[int'(a)] = d;
    end
  endtask

  task automatic write_segment(input logic [1:0] idx, input logic [15:0] val);
    @(negedge clk);
    seg_wr      = 1'b1;
    seg_wr_idx  = idx;
    seg_wr_data = val;
    @(negedge clk);
    seg_wr        = 1'b0;
    seg_vals[idx] = val;
  endtask

  // ========================================
  // One command, optionally with a strobe while busy
  // ========================================

  task automatic run_access(input x86_mem_pkg::mem_op_e op, input logic b8,
                            input logic [1:0] seg, input logic [15:0] off,
                            input logic [15:0] wd, input logic [2:0] tag,
                            input logic poke_busy);
    logic                    is_io;
    logic                    is_rd;
    logic [`X86_PADDR_W-1:0] pa;
    logic [`X86_PADDR_W-1:1] wa;
    logic [1:0]              sel0;
    int                      n_exp;
    is_io = (op == x86_mem_pkg::io_read) || (op == x86_mem_pkg::io_write);
    is_rd = (op == x86_mem_pkg::mem_read) || (op == x86_mem_pkg::io_read);
    // A port owns a word slot of its own space and is never split
    pa    = is_io ? {3'b000, off, 1'b0} : {seg_vals[seg], 4'h0} + {4'h0, off};
    wa    = pa[`X86_PADDR_W-1:1];
    sel0  = pa[0] ? 2'b10 : (b8 ? 2'b01 : 2'b11);
    n_exp = (pa[0] && !b8) ? 2 : 1;
    @(negedge clk);   // Previous write-back has been checked by now
    while (busy) begin
      @(negedge clk);
    end
    bus_log.delete();
    exp_wb.tag  = tag;
    exp_wb.data = {b8 ? 8'h00 : reference_byte(is_io, pa + 20'd1), reference_byte(is_io, pa)};
    cmd = '{op: op, is_8bit: b8, seg_sel: seg, dest_tag: tag, offset: off, wdata: wd};
    cmd_valid = 1'b1;
    @(negedge clk);
    cmd_valid = 1'b0;
    if (poke_busy) begin
      assert (busy) else note_problem("busy did not rise after a command");
      cmd = '{op: x86_mem_pkg::mem_write, is_8bit: 1'b0, seg_sel: seg, dest_tag: ~tag,
              offset: ~off, wdata: ~wd};
      cmd_valid = 1'b1;   // Decode has to drop this one
      @(negedge clk);
      cmd_valid = 1'b0;
    end
    while (!(wb_valid || store_done)) begin
      @(negedge clk);
    end
    assert ((wb_valid == is_rd) && (store_done == !is_rd))
      else note_problem("completion pulse of the wrong kind");
    assert (bus_log.size() == n_exp)
      else report_mismatch("bus cycles", 32'(n_exp), 32'(bus_log.size()));
    if (bus_log.size() > 0) begin
      assert (bus_log[0].addr == wa)
        else report_mismatch("bus address", 32'(wa), 32'(bus_log[0].addr));
      assert (bus_log[0].bytesel == sel0)
        else report_mismatch("byte select", 32'(sel0), 32'(bus_log[0].bytesel));
      assert ({bus_log[0].io, bus_log[0].wr_en} == {is_io, !is_rd})
        else report_mismatch("io and wr_en", 32'({is_io, !is_rd}),
                             32'({bus_log[0].io, bus_log[0].wr_en}));
    end
    if (n_exp == 2 && bus_log.size() == 2) begin
      assert (bus_log[1].addr == wa + 1'b1)
        else report_mismatch("second address", 32'(wa + 1'b1), 32'(bus_log[1].addr));
      assert (bus_log[1].bytesel == 2'b01)
        else report_mismatch("second select", 32'h1, 32'(bus_log[1].bytesel));
    end
    if (!is_rd) begin
      store_reference(is_io, pa, wd[7:0]);
      if (!b8) begin
        store_reference(is_io, pa + 20'd1, wd[15:8]);
      end
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    logic [31:0] rnd;
    logic [15:0] off;
    cmd_valid   = 1'b0;
    cmd         = '0;
    seg_wr      = 1'b0;
    seg_wr_idx  = '0;
    seg_wr_data = '0;
    repeat (RESET_CYCLES) @(negedge clk);

    begin_test("reset_state");
    assert (bus == '0) else note_problem("bus not quiet in reset");
    assert (!busy && !wb_valid && !store_done) else note_problem("status high in reset");
    reset = 1'b0;
    end_test();

    begin_test("segment_addr");
    for (int i = 0; i < `X86_NUM_SEG; i++) begin
      rnd = $random(seed);
      write_segment(2'(i), (i == 3) ? 16'h0000 : rnd[31:16]);   // Segment 3 stays flat
    end
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      off = {rnd[15:1], 1'b0};
      run_access(x86_mem_pkg::mem_write, 1'b0, rnd[17:16], off, rnd[31:16], 3'(i), 1'b0);
      run_access(x86_mem_pkg::mem_read, 1'b0, rnd[17:16], off, 16'h0000, 3'(i + 1), 1'b0);
    end
    end_test();

    begin_test("byte_access");
    for (int i = 0; i < 2; i++) begin
      off = 16'h0100 + 16'(i);   // Even lane, then odd lane
      run_access(x86_mem_pkg::mem_write, 1'b0, 2'd1, 16'h0100, 16'ha55a, 3'd1, 1'b0);
      run_access(x86_mem_pkg::mem_write, 1'b1, 2'd1, off, 16'hff3c, 3'd2, 1'b0);
      run_access(x86_mem_pkg::mem_read, 1'b1, 2'd1, off, 16'h0000, 3'd3, 1'b0);
      run_access(x86_mem_pkg::mem_read, 1'b0, 2'd1, 16'h0100, 16'h0000, 3'd4, 1'b0);
    end
    end_test();

    begin_test("unaligned_word");
    run_access(x86_mem_pkg::mem_write, 1'b0, 2'd2, 16'h2000, 16'h1122, 3'd0, 1'b0);
    run_access(x86_mem_pkg::mem_write, 1'b0, 2'd2, 16'h2002, 16'h3344, 3'd1, 1'b0);
    run_access(x86_mem_pkg::mem_write, 1'b0, 2'd2, 16'h2001, 16'hbeef, 3'd2, 1'b0);
    run_access(x86_mem_pkg::mem_read, 1'b0, 2'd2, 16'h2001, 16'h0000, 3'd3, 1'b0);
    run_access(x86_mem_pkg::mem_read, 1'b0, 2'd2, 16'h2000, 16'h0000, 3'd4, 1'b0);
    run_access(x86_mem_pkg::mem_read, 1'b0, 2'd2, 16'h2002, 16'h0000, 3'd5, 1'b0);
    end_test();

    // Segment 0 holds a nonzero base and any segment added to a port would show up
    // Memory byte 0x80 shares bus word address 0x40 with port 0x40
    begin_test("io_space");
    run_access(x86_mem_pkg::mem_write, 1'b0, 2'd3, 16'h0080, 16'h1111, 3'd0, 1'b0);
    run_access(x86_mem_pkg::io_write, 1'b0, 2'd0, 16'h0040, 16'h2222, 3'd1, 1'b0);
    run_access(x86_mem_pkg::io_read, 1'b0, 2'd0, 16'h0040, 16'h0000, 3'd2, 1'b0);
    run_access(x86_mem_pkg::io_read, 1'b1, 2'd0, 16'h0040, 16'h0000, 3'd3, 1'b0);
    run_access(x86_mem_pkg::mem_read, 1'b0, 2'd3, 16'h0080, 16'h0000, 3'd4, 1'b0);
    end_test();

    begin_test("busy_strobe");
    run_access(x86_mem_pkg::mem_write, 1'b0, 2'd0, 16'h0300, 16'hc0de, 3'd5, 1'b1);
    run_access(x86_mem_pkg::mem_read, 1'b0, 2'd0, 16'h0300, 16'h0000, 3'd6, 1'b1);
    end_test();

    repeat (2) @(negedge clk);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
